// ==== hw/mc_pkg.sv ====
package mc_pkg;

    // Host side widths
    typedef logic [63:0]  host_addr_t;
    typedef logic [15:0]  mmio_addr_t;
    typedef logic [63:0]  mmio_data_t;
    typedef logic [12:0]  line_cnt_t;
    typedef logic [511:0] dma_line_t;

    // Accelerator side widths
    typedef logic [31:0]  word_t;
    typedef logic [127:0] result_t;

    localparam int unsigned WORDS_PER_LINE = 16;
    localparam int unsigned RESULT_LANES   = 4;

    // MMIO write address fields
    localparam int unsigned MMIO_CLR_BIT = 1;
    localparam int unsigned MMIO_EN_BIT  = 15;
    localparam int unsigned MMIO_LEN_LSB = 2;
    localparam int unsigned MMIO_LEN_MSB = 14;

    // Low half of every main memory result address
    localparam logic [15:0] RESULT_ADDR_TAG = 16'hFFF0;

    localparam mmio_data_t STATUS_PATCH_DONE = 64'd1;
    localparam mmio_data_t STATUS_TERM       = 64'd2;

    // Word strobe index
    typedef enum logic {
        CP = 1'b0,
        RT = 1'b1
    } stream_e;

    typedef enum logic [1:0] {
        CMD_CP,
        CMD_RT,
        CMD_OUT
    } cmd_state_e;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_GO,
        FETCH_READ,
        FETCH_WORDS,
        FETCH_END
    } fetch_state_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_WAIT,
        WB_HOLD,
        WB_DONE
    } wb_state_e;

endpackage

// ==== hw/mc_desc_if.sv ====
`timescale 1ns/100ps

interface mc_desc_if;
    import mc_pkg::*;

    // Stream descriptors
    logic       cp_en;
    host_addr_t cp_addr;
    logic       rt_en;
    host_addr_t rt_addr;
    line_cnt_t  rt_lines;

    // Result write back base
    host_addr_t out_addr;

    // One cycle run start
    logic       start;

    modport cmd (output cp_en, cp_addr, rt_en, rt_addr, rt_lines, out_addr, start);

    modport fetch (input cp_en, cp_addr, rt_en, rt_addr, rt_lines, start);

    modport wb (input out_addr, start);

endinterface

// ==== hw/mc_cmd_decode.sv ====
`timescale 1ns/100ps

module mc_cmd_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mmio_wr_en,
    input  mc_pkg::mmio_addr_t mmio_wr_addr,
    input  mc_pkg::mmio_data_t mmio_wr_data,
    mc_desc_if.cmd             desc
);
    import mc_pkg::*;

    cmd_state_e state;
    cmd_state_e state_nxt;

    logic desc_wr;
    logic ld_cp;
    logic ld_rt;
    logic ld_out;

    // Clear writes never count as descriptors
    assign desc_wr = mmio_wr_en && !mmio_wr_addr[MMIO_CLR_BIT];

    assign ld_cp  = (state == CMD_CP) && desc_wr && mmio_wr_addr[MMIO_EN_BIT];
    assign ld_rt  = (state == CMD_RT) && desc_wr;
    assign ld_out = (state == CMD_OUT) && desc_wr;

    always_comb begin
        state_nxt = state;
        case (state)
            CMD_CP: begin
                if (ld_cp)
                    state_nxt = CMD_RT;
            end
            CMD_RT: begin
                if (ld_rt)
                    state_nxt = CMD_OUT;
            end
            CMD_OUT: begin
                if (ld_out)
                    state_nxt = CMD_CP;
            end
            default: state_nxt = CMD_CP;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= CMD_CP;
            desc.cp_en <= 1'b0;
            desc.rt_en <= 1'b0;
            desc.start <= 1'b0;
        end else begin
            state      <= state_nxt;
            desc.start <= ld_out;
            if (ld_cp)
                desc.cp_en <= mmio_wr_addr[MMIO_EN_BIT];
            if (ld_rt)
                desc.rt_en <= mmio_wr_addr[MMIO_EN_BIT];
        end
    end

    // Descriptor payload
    always_ff @(posedge clk) begin
        if (ld_cp)
            desc.cp_addr <= mmio_wr_data;
        if (ld_rt) begin
            desc.rt_addr  <= mmio_wr_data;
            desc.rt_lines <= mmio_wr_addr[MMIO_LEN_MSB:MMIO_LEN_LSB];
        end
        if (ld_out)
            desc.out_addr <= mmio_wr_data;
    end

    // A run needs three fresh descriptors before it can start again
    a_start_single: assert property (
        @(posedge clk) disable iff (!rst_n) desc.start |=> !desc.start
    ) else $error("start held for more than one cycle");

endmodule

// ==== hw/mc_stream_fetch.sv ====
`timescale 1ns/100ps

module mc_stream_fetch #(
    parameter int NUM_THREAD = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    mc_desc_if.fetch           desc,
    output logic               rd_go,
    output mc_pkg::host_addr_t rd_addr,
    output mc_pkg::line_cnt_t  rd_size,
    input  logic               rd_empty,
    output logic               rd_en,
    input  mc_pkg::dma_line_t  rd_data,
    output mc_pkg::word_t      data_32,
    output logic [1:0]         word_we,
    output logic               cp_strt,
    output mc_pkg::word_t      patch_total
);
    import mc_pkg::*;

    localparam int WCNT_W = $clog2(WORDS_PER_LINE);

    fetch_state_e state;
    fetch_state_e state_nxt;
    stream_e      cur;

    line_cnt_t          line_cnt;
    line_cnt_t          stream_lines;
    logic [WCNT_W-1:0]  word_cnt;
    logic               stream_en;
    logic               last_word;
    logic               last_line;
    word_t              line_sh [WORDS_PER_LINE];

    assign stream_en    = (cur == CP) ? desc.cp_en : desc.rt_en;
    assign stream_lines = (cur == CP) ? line_cnt_t'(1) : desc.rt_lines;
    assign last_word    = (word_cnt == WCNT_W'(WORDS_PER_LINE - 1));
    assign last_line    = ((line_cnt + line_cnt_t'(1)) >= stream_lines);

    assign rd_addr = (cur == CP) ? desc.cp_addr : desc.rt_addr;
    assign rd_size = stream_lines;
    assign rd_go   = (state == FETCH_GO) && stream_en;
    assign rd_en   = (state == FETCH_READ) && !rd_empty;
    assign cp_strt = (state == FETCH_END);
    assign data_32 = line_sh[0];

    always_comb begin
        word_we = '0;
        if (state == FETCH_WORDS)
            word_we[cur] = 1'b1;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH_IDLE: begin
                if (desc.start)
                    state_nxt = FETCH_GO;
            end
            FETCH_GO: begin
                if (stream_en)
                    state_nxt = FETCH_READ;
                else if (cur == RT)
                    state_nxt = FETCH_END;
            end
            FETCH_READ: begin
                if (!rd_empty)
                    state_nxt = FETCH_WORDS;
            end
            FETCH_WORDS: begin
                if (last_word && !last_line)
                    state_nxt = FETCH_READ;
                else if (last_word)
                    state_nxt = (cur == CP) ? FETCH_GO : FETCH_END;
            end
            default: state_nxt = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state       <= FETCH_IDLE;
            cur         <= CP;
            line_cnt    <= '0;
            word_cnt    <= '0;
            patch_total <= '0;
        end else begin
            state <= state_nxt;
            if (desc.start && state == FETCH_IDLE)
                cur <= CP;
            else if (cur == CP && state_nxt == FETCH_GO && state != FETCH_IDLE)
                cur <= RT;
            if (state == FETCH_GO)
                line_cnt <= '0;
            else if (state == FETCH_WORDS && last_word)
                line_cnt <= line_cnt + line_cnt_t'(1);
            if (rd_en)
                word_cnt <= '0;
            else if (state == FETCH_WORDS)
                word_cnt <= word_cnt + WCNT_W'(1);
            // First CP word is the work-item count
            if (state == FETCH_WORDS && cur == CP && word_cnt == '0)
                patch_total <= data_32 / NUM_THREAD;
        end
    end

    // Line shifter, word 0 leaves first
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < WORDS_PER_LINE; i++)
                line_sh[i] <= rd_data[i*32 +: 32];
        end else if (state == FETCH_WORDS) begin
            for (int i = 0; i < WORDS_PER_LINE - 1; i++)
                line_sh[i] <= line_sh[i+1];
        end
    end

    a_rd_no_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rd_en |-> !rd_empty
    ) else $error("rd_en while rd_empty");

endmodule

// ==== hw/mc_result_writeback.sv ====
`timescale 1ns/100ps

module mc_result_writeback #(
    parameter int NUM_THREAD     = 32,
    parameter int RESULT_LATENCY = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mmio_wr_en,
    input  mc_pkg::mmio_addr_t mmio_wr_addr,
    output mc_pkg::mmio_data_t mmio_rd_data,
    mc_desc_if.wb              desc,
    input  mc_pkg::word_t      patch_total,
    input  logic               patch_done,
    output logic               re_main,
    output mc_pkg::word_t      addr_main [mc_pkg::RESULT_LANES],
    input  mc_pkg::result_t    result [mc_pkg::RESULT_LANES],
    output logic               wr_go,
    output mc_pkg::host_addr_t wr_addr,
    input  logic               wr_full,
    output logic               wr_en,
    output mc_pkg::dma_line_t  wr_data,
    input  logic               wr_done,
    output logic               wr_out_done,
    output logic               term
);
    import mc_pkg::*;

    localparam int LINES_PER_PATCH = NUM_THREAD / RESULT_LANES;
    localparam int STEP_W          = $clog2(LINES_PER_PATCH + 1);
    localparam int LAT_W           = $clog2(RESULT_LATENCY + 1);

    wb_state_e state;
    wb_state_e state_nxt;

    logic [LAT_W-1:0]  lat_cnt;
    logic [STEP_W-1:0] step;
    word_t             patch_cnt;
    logic              capture;
    logic              last_step;
    logic              last_patch;
    logic              patch_adv;
    logic              status_clr;

    assign last_step  = (step == STEP_W'(LINES_PER_PATCH));
    assign last_patch = ((patch_cnt + word_t'(1)) == patch_total);
    assign patch_adv  = (state == WB_DONE) && wr_done;
    assign status_clr = mmio_wr_en && mmio_wr_addr[MMIO_CLR_BIT];

    // Thread index in the upper half, fixed tag below
    always_comb begin
        for (int k = 0; k < RESULT_LANES; k++)
            addr_main[k] = {16'(step * RESULT_LANES + k), RESULT_ADDR_TAG};
    end

    always_comb begin
        state_nxt   = state;
        wr_go       = 1'b0;
        re_main     = 1'b0;
        wr_en       = 1'b0;
        capture     = 1'b0;
        wr_out_done = 1'b0;
        term        = 1'b0;
        case (state)
            WB_IDLE: begin
                if (patch_done) begin
                    wr_go     = 1'b1;
                    re_main   = 1'b1;
                    state_nxt = WB_WAIT;
                end
            end
            WB_WAIT: begin
                if (lat_cnt == LAT_W'(RESULT_LATENCY)) begin
                    capture   = 1'b1;
                    state_nxt = WB_HOLD;
                end
            end
            WB_HOLD: begin
                if (!wr_full) begin
                    wr_en = 1'b1;
                    if (last_step) begin
                        state_nxt = WB_DONE;
                    end else begin
                        re_main   = 1'b1;
                        state_nxt = WB_WAIT;
                    end
                end
            end
            default: begin
                if (wr_done) begin
                    term        = last_patch;
                    wr_out_done = !last_patch;
                    state_nxt   = WB_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state        <= WB_IDLE;
            lat_cnt      <= '0;
            step         <= '0;
            patch_cnt    <= '0;
            mmio_rd_data <= '0;
        end else begin
            state <= state_nxt;
            if (re_main)
                lat_cnt <= LAT_W'(1);
            else if (state == WB_WAIT)
                lat_cnt <= lat_cnt + LAT_W'(1);
            // Step moves ahead at capture so re_main in HOLD sees the next one
            if (wr_en && last_step)
                step <= '0;
            else if (capture)
                step <= step + STEP_W'(1);
            if (term)
                patch_cnt <= '0;
            else if (wr_out_done)
                patch_cnt <= patch_cnt + word_t'(1);
            if (status_clr)
                mmio_rd_data <= '0;
            else if (term)
                mmio_rd_data <= STATUS_TERM;
            else if (wr_out_done)
                mmio_rd_data <= STATUS_PATCH_DONE;
        end
    end

    // Lane 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int k = 0; k < RESULT_LANES; k++)
                wr_data[k*128 +: 128] <= result[k];
        end
        if (desc.start)
            wr_addr <= desc.out_addr;
        else if (patch_adv)
            wr_addr <= wr_addr + host_addr_t'(LINES_PER_PATCH);
    end

    a_wr_no_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> !wr_full
    ) else $error("wr_en while wr_full");

endmodule

// ==== hw/mem_controller.sv ====
`timescale 1ns/100ps

module mem_controller #(
    parameter int NUM_THREAD     = 32,
    parameter int RESULT_LATENCY = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    // MMIO
    input  logic               mmio_wr_en,
    input  mc_pkg::mmio_addr_t mmio_wr_addr,
    input  mc_pkg::mmio_data_t mmio_wr_data,
    output mc_pkg::mmio_data_t mmio_rd_data,
    // DMA read
    output logic               rd_go,
    output mc_pkg::host_addr_t rd_addr,
    output mc_pkg::line_cnt_t  rd_size,
    input  logic               rd_empty,
    output logic               rd_en,
    input  mc_pkg::dma_line_t  rd_data,
    // DMA write
    output logic               wr_go,
    output mc_pkg::host_addr_t wr_addr,
    input  logic               wr_full,
    output logic               wr_en,
    output mc_pkg::dma_line_t  wr_data,
    input  logic               wr_done,
    // Accelerator
    output mc_pkg::word_t      data_32,
    output logic [1:0]         word_we,
    output logic               cp_strt,
    input  logic               patch_done,
    output logic               re_main,
    output mc_pkg::word_t      addr_main [mc_pkg::RESULT_LANES],
    input  mc_pkg::result_t    result [mc_pkg::RESULT_LANES],
    output logic               wr_out_done,
    output logic               term
);
    import mc_pkg::*;

    word_t patch_total;

    mc_desc_if desc ();

    mc_cmd_decode i_cmd_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .desc         (desc.cmd)
    );

    mc_stream_fetch #(
        .NUM_THREAD (NUM_THREAD)
    ) i_stream_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .desc        (desc.fetch),
        .rd_go       (rd_go),
        .rd_addr     (rd_addr),
        .rd_size     (rd_size),
        .rd_empty    (rd_empty),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .data_32     (data_32),
        .word_we     (word_we),
        .cp_strt     (cp_strt),
        .patch_total (patch_total)
    );

    mc_result_writeback #(
        .NUM_THREAD     (NUM_THREAD),
        .RESULT_LATENCY (RESULT_LATENCY)
    ) i_result_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_rd_data (mmio_rd_data),
        .desc         (desc.wb),
        .patch_total  (patch_total),
        .patch_done   (patch_done),
        .re_main      (re_main),
        .addr_main    (addr_main),
        .result       (result),
        .wr_go        (wr_go),
        .wr_addr      (wr_addr),
        .wr_full      (wr_full),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_done      (wr_done),
        .wr_out_done  (wr_out_done),
        .term         (term)
    );

endmodule

// ==== bench/tb_mem_controller.sv ====
`timescale 1ns/100ps

module tb_mem_controller;
    import mc_pkg::*;

    localparam int NUM_THREAD      = 32;
    localparam int RESULT_LATENCY  = 4;
    localparam int LINES_PER_PATCH = NUM_THREAD / RESULT_LANES;
    localparam int N_ROWS          = 4;
    localparam int DONE_DELAY      = 3;

    typedef struct packed {
        logic       cp_en;
        logic       rt_en;
        line_cnt_t  rt_lines;
        host_addr_t cp_addr;
        host_addr_t rt_addr;
        host_addr_t out_addr;
        word_t      cp_word;
        logic       stall;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       mmio_wr_en;
    mmio_addr_t mmio_wr_addr;
    mmio_data_t mmio_wr_data;
    mmio_data_t mmio_rd_data;
    logic       rd_go;
    host_addr_t rd_addr;
    line_cnt_t  rd_size;
    logic       rd_empty;
    logic       rd_en;
    dma_line_t  rd_data;
    logic       wr_go;
    host_addr_t wr_addr;
    logic       wr_full;
    logic       wr_en;
    dma_line_t  wr_data;
    logic       wr_done;
    word_t      data_32;
    logic [1:0] word_we;
    logic       cp_strt;
    logic       patch_done;
    logic       re_main;
    word_t      addr_main [RESULT_LANES];
    result_t    result [RESULT_LANES];
    logic       wr_out_done;
    logic       term;

    row_t        rows [N_ROWS];
    row_t        cur;
    int          errors = 0;
    int          checks = 0;
    int          budget = 0;
    int          rd_go_cnt;
    int          wr_go_cnt;
    int          strt_cnt;
    int          out_done_cnt;
    int          term_cnt;
    int          wr_lines;
    int          words [2];
    int          rd_line = 0;
    int          wr_step = 0;
    int          re_step = 0;
    int          lat_left = 0;
    int          done_wait = 0;
    host_addr_t  rd_base = '0;
    word_t       pend_addr [RESULT_LANES];
    logic [31:0] lfsr = 32'd97014;

    mem_controller #(
        .NUM_THREAD     (NUM_THREAD),
        .RESULT_LATENCY (RESULT_LATENCY)
    ) i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Word 0 of the CP line holds the work-item count
    function automatic word_t host_word(host_addr_t a, int k);
        if (a == cur.cp_addr && k == 0)
            return cur.cp_word;
        return word_t'(a * 16 + k);
    endfunction

    function automatic result_t lane_value(word_t a);
        return {a ^ 32'hdead_beef, a + 32'h1357_9bdf, ~a, a};
    endfunction

    function automatic word_t lane_addr(int step, int k);
        return {16'(step * RESULT_LANES + k), RESULT_ADDR_TAG};
    endfunction

    function automatic dma_line_t expected_line(int step);
        dma_line_t line;
        for (int k = 0; k < RESULT_LANES; k++)
            line[k*128 +: 128] = lane_value(lane_addr(step, k));
        return line;
    endfunction

    task automatic report_failure(string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic expect_count(string what, int got, int exp);
        checks++;
        if (got != exp)
            report_failure($sformatf("%s seen %0d times where %0d were expected",
                                     what, got, exp));
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(string name, dma_line_t got, dma_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, host_addr_t got, host_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_size(string name, line_cnt_t got, line_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_status(string name, mmio_data_t got, mmio_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic mmio_write(mmio_addr_t addr, mmio_data_t data);
        mmio_wr_en   = 1'b1;
        mmio_wr_addr = addr;
        mmio_wr_data = data;
        @(negedge clk);
        mmio_wr_en   = 1'b0;
    endtask

    task automatic clear_counts();
        rd_go_cnt    = 0;
        wr_go_cnt    = 0;
        strt_cnt     = 0;
        out_done_cnt = 0;
        term_cnt     = 0;
        wr_lines     = 0;
        words[0]     = 0;
        words[1]     = 0;
    endtask

    // Monitor samples the pre-edge values
    always @(posedge clk) begin
        if (rd_go) begin
            check_addr("rd_addr", rd_addr, (rd_go_cnt == 0) ? cur.cp_addr : cur.rt_addr);
            check_size("rd_size", rd_size, (rd_go_cnt == 0) ? line_cnt_t'(1) : cur.rt_lines);
            rd_base = rd_addr;
            rd_line = 0;
            rd_go_cnt++;
        end
        if (rd_en && rd_empty)
            report_failure("rd_en asserted while rd_empty was high");
        if (rd_en)
            rd_line++;
        for (int s = 0; s < 2; s++) begin
            if (word_we[s]) begin
                check_word("data_32", data_32,
                    host_word(((s == CP) ? cur.cp_addr : cur.rt_addr)
                              + host_addr_t'(words[s] / WORDS_PER_LINE),
                              words[s] % WORDS_PER_LINE));
                words[s]++;
            end
        end
        if (word_we != 2'b00 && strt_cnt != 0)
            report_failure("word strobe after cp_strt");
        if (cp_strt)
            strt_cnt++;
        if (wr_go) begin
            check_addr("wr_addr", wr_addr,
                cur.out_addr + host_addr_t'((out_done_cnt + term_cnt) * LINES_PER_PATCH));
            wr_step = 0;
            re_step = 0;
            wr_go_cnt++;
        end
        if (re_main) begin
            for (int k = 0; k < RESULT_LANES; k++) begin
                check_word($sformatf("addr_main[%0d]", k), addr_main[k], lane_addr(re_step, k));
                pend_addr[k] = addr_main[k];
            end
            lat_left = RESULT_LATENCY;
            re_step++;
        end
        if (wr_en && wr_full)
            report_failure("wr_en asserted while wr_full was high");
        if (wr_en) begin
            check_line("wr_data", wr_data, expected_line(wr_step));
            wr_step++;
            wr_lines++;
            if (wr_step == LINES_PER_PATCH)
                done_wait = DONE_DELAY;
        end
        if (wr_out_done)
            out_done_cnt++;
        if (term)
            term_cnt++;
    end

    // Host DMA and result memory models
    always @(negedge clk) begin : drive_models
        logic res_ok;
        rd_empty = cur.stall && lfsr[0];
        lfsr = lfsr_step(lfsr);
        wr_full = cur.stall && lfsr[0];
        lfsr = lfsr_step(lfsr);
        for (int k = 0; k < WORDS_PER_LINE; k++)
            rd_data[k*32 +: 32] = host_word(rd_base + host_addr_t'(rd_line), k);
        res_ok = (lat_left == 1);
        if (lat_left != 0)
            lat_left--;
        for (int k = 0; k < RESULT_LANES; k++)
            result[k] = res_ok ? lane_value(pend_addr[k]) : '0;
        wr_done = (done_wait == 1);
        if (done_wait != 0)
            done_wait--;
    end

    initial begin
        int         npatch;
        int         row_err;
        mmio_addr_t a;
        cur          = '0;
        rst_n        = 1'b0;
        mmio_wr_en   = 1'b0;
        mmio_wr_addr = '0;
        mmio_wr_data = '0;
        patch_done   = 1'b0;
        rd_empty     = 1'b0;
        rd_data      = '0;
        wr_full      = 1'b0;
        wr_done      = 1'b0;
        for (int k = 0; k < RESULT_LANES; k++)
            result[k] = '0;
        clear_counts();
        // cp_en, rt_en, rt_lines, cp_addr, rt_addr, out_addr, cp_word, stall
        rows[0] = '{1'b1, 1'b1, 13'd2, 64'h100, 64'h200, 64'h1000, 32'd64, 1'b0};
        rows[1] = '{1'b1, 1'b0, 13'd3, 64'h180, 64'h280, 64'h2000, 32'd32, 1'b0};
        rows[2] = '{1'b1, 1'b1, 13'd3, 64'h300, 64'h400, 64'h3000, 32'd96, 1'b1};
        rows[3] = '{1'b1, 1'b1, 13'd1, 64'h500, 64'h600, 64'h4000, 32'd70, 1'b1};
        budget = 200;
        for (int r = 0; r < N_ROWS; r++)
            budget += 60 * (1 + rows[r].rt_lines) + 2 * (rows[r].cp_word / NUM_THREAD)
                      * (LINES_PER_PATCH * (RESULT_LATENCY + 4) + DONE_DELAY + 10);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int r = 0; r < N_ROWS; r++) begin
            cur     = rows[r];
            row_err = errors;
            clear_counts();
            a = '0;
            a[MMIO_EN_BIT] = cur.cp_en;
            mmio_write(a, cur.cp_addr);
            a[MMIO_EN_BIT] = cur.rt_en;
            a[MMIO_LEN_MSB:MMIO_LEN_LSB] = cur.rt_lines;
            mmio_write(a, cur.rt_addr);
            mmio_write('0, cur.out_addr);
            while (strt_cnt == 0)
                @(negedge clk);
            repeat (2) @(negedge clk);
            expect_count("rd_go", rd_go_cnt, 1 + cur.rt_en);
            expect_count("cp_strt", strt_cnt, 1);
            expect_count("cp words", words[CP], WORDS_PER_LINE);
            expect_count("rt words", words[RT], cur.rt_en ? WORDS_PER_LINE * cur.rt_lines : 0);

            npatch = cur.cp_word / NUM_THREAD;
            for (int p = 0; p < npatch; p++) begin
                patch_done = 1'b1;
                @(negedge clk);
                patch_done = 1'b0;
                while (out_done_cnt + term_cnt <= p)
                    @(negedge clk);
                check_status("mmio_rd_data", mmio_rd_data,
                             (p == npatch - 1) ? STATUS_TERM : STATUS_PATCH_DONE);
            end
            expect_count("wr_go", wr_go_cnt, npatch);
            expect_count("wr_out_done", out_done_cnt, npatch - 1);
            expect_count("term", term_cnt, 1);
            expect_count("written lines", wr_lines, npatch * LINES_PER_PATCH);

            // Status clear write
            a = '0;
            a[MMIO_CLR_BIT] = 1'b1;
            mmio_write(a, '0);
            check_status("mmio_rd_data", mmio_rd_data, '0);
            $display("row %0d: rt_en %0b, %0d patches, stall %0b, %s", r, cur.rt_en, npatch,
                     cur.stall, (errors == row_err) ? "ok" : "failed");
        end

        $display("%0d rows, %0d checks, %0d errors", N_ROWS, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        wait (budget != 0);
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles with the run unfinished", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
hw/mc_pkg.sv
hw/mc_desc_if.sv
hw/mc_cmd_decode.sv
hw/mc_stream_fetch.sv
hw/mc_result_writeback.sv
hw/mem_controller.sv
bench/tb_mem_controller.sv

// ==== Bender.yml ====
package:
  name: mem_controller

sources:
  - hw/mc_pkg.sv
  - hw/mc_desc_if.sv
  - hw/mc_cmd_decode.sv
  - hw/mc_stream_fetch.sv
  - hw/mc_result_writeback.sv
  - hw/mem_controller.sv
  - target: simulation
    files:
      - bench/tb_mem_controller.sv
